/* Bender.yml */
package:
  name: axi_delay

sources:
  - verilog/axi_delay_pkg.sv
  - verilog/r_channel_delayer.sv
  - verilog/b_channel_delayer.sv
  - verilog/axi_sram_device.sv
  - verilog/axi_delay_top.sv
  - target: test
    files:
      - verif/axi_delay_tb.sv

/* src.f */
verilog/axi_delay_pkg.sv
verilog/r_channel_delayer.sv
verilog/b_channel_delayer.sv
verilog/axi_sram_device.sv
verilog/axi_delay_top.sv
verif/axi_delay_tb.sv

/* verif/axi_delay_tb.sv */
module axi_delay_tb import axi_delay_pkg::*; ();

  // same values as the defaults of axi_delay_top
  localparam int unsigned scale = 88;
  localparam int unsigned latency = 4;
  localparam int unsigned depth = 256;
  localparam int unsigned timeout = 2000;
  localparam int unsigned num_trans = 200;

  logic    clock;
  logic    reset;
  logic    ar_valid;
  axi_ax_t ar;
  logic    ar_ready;
  logic    r_valid;
  axi_r_t  r;
  logic    r_ready;
  logic    aw_valid;
  axi_ax_t aw;
  logic    aw_ready;
  logic    w_valid;
  axi_w_t  w;
  logic    w_ready;
  logic    b_valid;
  axi_b_t  b;
  logic    b_ready;

  logic [31:0] lfsr;
  axi_data_t   model [depth];
  int unsigned cycle_count;

  axi_delay_top axi_delay_top_inst (
    .clock(clock),
    .reset(reset),
    .ar_valid(ar_valid),
    .ar(ar),
    .ar_ready(ar_ready),
    .r_valid(r_valid),
    .r(r),
    .r_ready(r_ready),
    .aw_valid(aw_valid),
    .aw(aw),
    .aw_ready(aw_ready),
    .w_valid(w_valid),
    .w(w),
    .w_ready(w_ready),
    .b_valid(b_valid),
    .b(b),
    .b_ready(b_ready)
  );

  always #4 clock = ~clock;

  // index of the last rising edge
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    logic        bit_out;
    value = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr[0];
      lfsr = (lfsr >> 1) ^ (bit_out ? 32'h80200003 : 32'h0);
      value = {value[30:0], bit_out};
    end
    return value;
  endfunction

  function automatic axi_data_t fill_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'ha5, a + 8'h3c};
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_latency(input string name, input int unsigned lo, input int unsigned act);
    if (act < lo || act > lo + 3) begin
      $display("Error at %0t: %s expected %0d to %0d cycles, got %0d",
               $time, name, lo, lo + 3, act);
      stop_run();
    end
  endtask

  task automatic check_reset_state();
    if (r_valid !== 1'b0 || b_valid !== 1'b0 || ar_ready !== 1'b0 || aw_ready !== 1'b0) begin
      $display("a valid or ready output is high during or right after reset");
      stop_run();
    end
  endtask

  // no response may show up between bursts
  task automatic check_quiet();
    if (r_valid || b_valid) begin
      $display("R beat or B response arrived outside any burst");
      stop_run();
    end
  endtask

  task automatic send_ar(input axi_ax_t a, output int unsigned t_hs);
    int unsigned waited;
    waited = 0;
    @(negedge clock);
    ar = a;
    ar_valid = 1'b1;
    #1;
    check_quiet();
    while (!ar_ready) begin
      if (waited == timeout) begin
        $display("AR handshake timed out");
        stop_run();
      end
      waited++;
      @(negedge clock);
      #1;
      check_quiet();
    end
    t_hs = cycle_count + 1;
  endtask

  task automatic send_aw(input axi_ax_t a, output int unsigned t_hs);
    int unsigned waited;
    waited = 0;
    @(negedge clock);
    aw = a;
    aw_valid = 1'b1;
    #1;
    check_quiet();
    while (!aw_ready) begin
      if (waited == timeout) begin
        $display("AW handshake timed out");
        stop_run();
      end
      waited++;
      @(negedge clock);
      #1;
      check_quiet();
    end
    t_hs = cycle_count + 1;
  endtask

  task automatic send_w(input axi_w_t beat, output int unsigned t_hs);
    int unsigned waited;
    waited = 0;
    @(negedge clock);
    aw_valid = 1'b0;
    w = beat;
    w_valid = 1'b1;
    #1;
    while (!w_ready) begin
      if (waited == timeout) begin
        $display("W handshake timed out");
        stop_run();
      end
      waited++;
      @(negedge clock);
      #1;
    end
    t_hs = cycle_count + 1;
  endtask

  task automatic do_read(input axi_id_t id, input logic [7:0] waddr, input axi_len_t len,
                         input logic stall);
    axi_ax_t     a;
    axi_r_t      held;
    logic        was_stalled;
    logic        seen;
    int unsigned t_hs;
    int unsigned beats;
    int unsigned waited;
    int unsigned lo;
    a.id = id;
    a.addr = axi_addr_t'({waddr, 2'b00});
    a.len = len;
    a.size = 3'd2;
    a.burst = 2'b01;
    send_ar(a, t_hs);
    beats = 0;
    waited = 0;
    seen = 1'b0;
    was_stalled = 1'b0;
    held = '0;
    lo = latency + (((latency - 1) * scale) >> delay_frac_bits);
    while (beats <= len) begin
      @(negedge clock);
      ar_valid = 1'b0;
      r_ready = stall ? (rand_bits(2) != 0) : 1'b1;
      #1;
      if (b_valid) begin
        $display("B response arrived during a read burst");
        stop_run();
      end
      if (was_stalled) begin
        check_last("r_valid while stalled", 1'b1, r_valid);
        check_id("r.id while stalled", held.id, r.id);
        check_data("r.data while stalled", held.data, r.data);
        check_last("r.last while stalled", held.last, r.last);
      end
      if (r_valid && !seen) begin
        seen = 1'b1;
        if (len == 0 && !stall) begin
          check_latency("AR to r_valid", lo, cycle_count - t_hs);
        end
      end
      was_stalled = r_valid && !r_ready;
      held = r;
      if (r_valid && r_ready) begin
        check_id("r.id", id, r.id);
        check_data("r.data", model[(waddr + beats) % depth], r.data);
        check_resp("r.resp", resp_okay, r.resp);
        check_last("r.last", beats == len, r.last);
        beats++;
        waited = 0;
      end else begin
        if (waited == timeout) begin
          $display("read burst stalled with no R beat");
          stop_run();
        end
        waited++;
      end
    end
  endtask

  task automatic do_write(input axi_id_t id, input logic [7:0] waddr, input axi_len_t len,
                          input logic stall, input logic fill);
    axi_ax_t     a;
    axi_w_t      beat;
    axi_b_t      held;
    logic        was_stalled;
    logic        seen;
    logic        done;
    int unsigned t_aw;
    int unsigned t_w;
    int unsigned widx;
    int unsigned waited;
    int unsigned lo;
    a.id = id;
    a.addr = axi_addr_t'({waddr, 2'b00});
    a.len = len;
    a.size = 3'd2;
    a.burst = 2'b01;
    send_aw(a, t_aw);
    t_w = t_aw;
    for (int i = 0; i <= len; i++) begin
      widx = (waddr + i) % depth;
      beat.data = fill ? fill_word(widx[7:0]) : rand_bits(32);
      beat.strb = fill ? 4'hf : axi_strb_t'(rand_bits(4));
      beat.last = (i == len);
      send_w(beat, t_w);
      for (int j = 0; j < 4; j++) begin
        if (beat.strb[j]) begin
          model[widx][8*j +: 8] = beat.data[8*j +: 8];
        end
      end
    end
    // wait counted from the AW handshake, hold seen from the last W beat
    lo = latency + (((t_w - t_aw + latency - 1) * scale) >> delay_frac_bits);
    waited = 0;
    seen = 1'b0;
    done = 1'b0;
    was_stalled = 1'b0;
    held = '0;
    while (!done) begin
      @(negedge clock);
      w_valid = 1'b0;
      b_ready = stall ? (rand_bits(2) != 0) : 1'b1;
      #1;
      if (r_valid) begin
        $display("R beat arrived during a write");
        stop_run();
      end
      if (was_stalled) begin
        check_last("b_valid while stalled", 1'b1, b_valid);
        check_id("b.id while stalled", held.id, b.id);
      end
      if (b_valid && !seen) begin
        seen = 1'b1;
        if (len == 0 && !stall) begin
          check_latency("W last to b_valid", lo, cycle_count - t_w);
        end
      end
      was_stalled = b_valid && !b_ready;
      held = b;
      if (b_valid && b_ready) begin
        check_id("b.id", id, b.id);
        check_resp("b.resp", resp_okay, b.resp);
        done = 1'b1;
      end else begin
        if (waited == timeout) begin
          $display("write response never arrived");
          stop_run();
        end
        waited++;
      end
    end
  endtask

  initial begin
    logic        is_write;
    logic        stall;
    axi_id_t     id;
    logic [7:0]  waddr;
    axi_len_t    len;
    clock = 1'b0;
    reset = 1'b1;
    lfsr = 32'h80752cd7;
    cycle_count = 0;
    ar_valid = 1'b0;
    ar = '0;
    r_ready = 1'b1;
    aw_valid = 1'b0;
    aw = '0;
    w_valid = 1'b0;
    w = '0;
    b_ready = 1'b1;
    repeat (16) begin
      @(negedge clock);
      check_reset_state();
    end
    reset = 1'b0;
    #1;
    check_reset_state();

    // known contents everywhere before random traffic
    for (int k = 0; k < depth / 8; k++) begin
      do_write(axi_id_t'(k), 8'(k * 8), 8'd7, 1'b0, 1'b1);
    end

    for (int n = 0; n < num_trans; n++) begin
      is_write = rand_bits(1);
      id = rand_bits(4);
      waddr = rand_bits(8);
      len = rand_bits(3);
      stall = rand_bits(1);
      if (is_write) begin
        do_write(id, waddr, len, stall, 1'b0);
      end else begin
        do_read(id, waddr, len, stall);
      end
    end

    // read everything back once
    for (int k = 0; k < depth / 8; k++) begin
      do_read(axi_id_t'(k), 8'(k * 8), 8'd7, 1'b0);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* verilog/axi_delay_pkg.sv */
package axi_delay_pkg;

  typedef logic [3:0]  axi_id_t;
  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [2:0]  axi_size_t;
  typedef logic [1:0]  axi_burst_t;
  typedef logic [1:0]  axi_resp_t;

  typedef logic [15:0] delay_t;
  typedef logic [31:0] delay_acc_t;

  // ratio is delay_scale / 2**delay_frac_bits
  localparam int unsigned delay_frac_bits = 4;

  localparam axi_resp_t resp_okay = 2'b00;

  // shared by AR and AW
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef enum logic [2:0] {
    sram_idle,
    sram_read_wait,
    sram_read_beats,
    sram_write_beats,
    sram_write_wait,
    sram_write_resp
  } sram_state_e;

  typedef enum logic {
    wait_idle,
    wait_waiting
  } wait_state_e;

endpackage

/* verilog/axi_delay_top.sv */
module axi_delay_top import axi_delay_pkg::*; #(
  parameter int unsigned delay_scale = 88,
  parameter int unsigned burst_max = 16,
  parameter int unsigned access_latency = 4,
  parameter int unsigned mem_words = 256
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    ar_valid,
  input  axi_ax_t ar,
  output logic    ar_ready,
  output logic    r_valid,
  output axi_r_t  r,
  input  logic    r_ready,
  input  logic    aw_valid,
  input  axi_ax_t aw,
  output logic    aw_ready,
  input  logic    w_valid,
  input  axi_w_t  w,
  output logic    w_ready,
  output logic    b_valid,
  output axi_b_t  b,
  input  logic    b_ready
);

  logic   dev_ar_valid;
  logic   dev_ar_ready;
  logic   dev_r_valid;
  logic   dev_r_ready;
  axi_r_t dev_r;
  logic   dev_aw_valid;
  logic   dev_aw_ready;
  logic   dev_b_valid;
  logic   dev_b_ready;
  axi_b_t dev_b;

  r_channel_delayer #(
    .delay_scale(delay_scale),
    .burst_max(burst_max)
  ) r_channel_delayer_inst (
    .clock(clock),
    .reset(reset),
    .cpu_ar_valid(ar_valid),
    .cpu_ar(ar),
    .cpu_ar_ready(ar_ready),
    .dev_ar_valid(dev_ar_valid),
    .dev_ar_ready(dev_ar_ready),
    .dev_r_valid(dev_r_valid),
    .dev_r(dev_r),
    .dev_r_ready(dev_r_ready),
    .cpu_r_valid(r_valid),
    .cpu_r(r),
    .cpu_r_ready(r_ready)
  );

  b_channel_delayer #(
    .delay_scale(delay_scale)
  ) b_channel_delayer_inst (
    .clock(clock),
    .reset(reset),
    .cpu_aw_valid(aw_valid),
    .cpu_aw(aw),
    .cpu_aw_ready(aw_ready),
    .dev_aw_valid(dev_aw_valid),
    .dev_aw_ready(dev_aw_ready),
    .dev_b_valid(dev_b_valid),
    .dev_b(dev_b),
    .dev_b_ready(dev_b_ready),
    .cpu_b_valid(b_valid),
    .cpu_b(b),
    .cpu_b_ready(b_ready)
  );

  // address payloads and the whole W channel go straight to the device
  axi_sram_device #(
    .access_latency(access_latency),
    .mem_words(mem_words)
  ) axi_sram_device_inst (
    .clock(clock),
    .reset(reset),
    .ar_valid(dev_ar_valid),
    .ar(ar),
    .ar_ready(dev_ar_ready),
    .r_valid(dev_r_valid),
    .r(dev_r),
    .r_ready(dev_r_ready),
    .aw_valid(dev_aw_valid),
    .aw(aw),
    .aw_ready(dev_aw_ready),
    .w_valid(w_valid),
    .w(w),
    .w_ready(w_ready),
    .b_valid(dev_b_valid),
    .b(dev_b),
    .b_ready(dev_b_ready)
  );

endmodule

/* verilog/axi_sram_device.sv */
module axi_sram_device import axi_delay_pkg::*; #(
  parameter int unsigned access_latency = 4,
  parameter int unsigned mem_words = 256
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    ar_valid,
  input  axi_ax_t ar,
  output logic    ar_ready,
  output logic    r_valid,
  output axi_r_t  r,
  input  logic    r_ready,
  input  logic    aw_valid,
  input  axi_ax_t aw,
  output logic    aw_ready,
  input  logic    w_valid,
  input  axi_w_t  w,
  output logic    w_ready,
  output logic    b_valid,
  output axi_b_t  b,
  input  logic    b_ready
);

  localparam int unsigned idx_w = $clog2(mem_words);
  localparam int unsigned lat_w = $clog2(access_latency + 1);

  axi_data_t mem [mem_words];

  sram_state_e      state;
  logic             started;
  logic [lat_w-1:0] lat_cnt;
  logic [idx_w-1:0] idx;
  axi_len_t         beat_cnt;
  axi_len_t         len_q;
  axi_id_t          id_q;
  logic ar_fire;
  logic aw_fire;
  logic r_fire;
  logic w_fire;
  logic b_fire;

  // ready stays low for the first cycle out of reset
  assign ar_ready = started && (state == sram_idle);
  assign aw_ready = started && (state == sram_idle) && !ar_valid;
  assign w_ready = (state == sram_write_beats);
  assign r_valid = (state == sram_read_beats);
  assign b_valid = (state == sram_write_resp);

  assign ar_fire = ar_valid && ar_ready;
  assign aw_fire = aw_valid && aw_ready;
  assign r_fire = r_valid && r_ready;
  assign w_fire = w_valid && w_ready;
  assign b_fire = b_valid && b_ready;

  assign r.id = id_q;
  assign r.data = mem[idx];
  assign r.resp = resp_okay;
  assign r.last = (beat_cnt == len_q);
  assign b.id = id_q;
  assign b.resp = resp_okay;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= sram_idle;
      started <= 1'b0;
      lat_cnt <= '0;
      beat_cnt <= '0;
    end else begin
      started <= 1'b1;
      case (state)
        sram_idle: begin
          beat_cnt <= '0;
          if (ar_fire) begin
            state <= (access_latency == 1) ? sram_read_beats : sram_read_wait;
            lat_cnt <= lat_w'(access_latency - 1);
          end else if (aw_fire) begin
            state <= sram_write_beats;
          end
        end
        sram_read_wait: begin
          if (lat_cnt == lat_w'(1)) begin
            state <= sram_read_beats;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        sram_read_beats: begin
          if (r_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (r.last) begin
              state <= sram_idle;
            end
          end
        end
        sram_write_beats: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (w.last) begin
              state <= (access_latency == 1) ? sram_write_resp : sram_write_wait;
              lat_cnt <= lat_w'(access_latency - 1);
            end
          end
        end
        sram_write_wait: begin
          if (lat_cnt == lat_w'(1)) begin
            state <= sram_write_resp;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        sram_write_resp: begin
          if (b_fire) begin
            state <= sram_idle;
          end
        end
        default: state <= sram_idle;
      endcase
    end
  end

  // burst context, word index from the byte address
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      idx <= ar.addr[idx_w+1:2];
      len_q <= ar.len;
      id_q <= ar.id;
    end else if (aw_fire) begin
      idx <= aw.addr[idx_w+1:2];
      len_q <= aw.len;
      id_q <= aw.id;
    end else if (r_fire || w_fire) begin
      idx <= idx + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (w_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i]) begin
          mem[idx][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
  end

  a_w_last: assert property (@(posedge clock) disable iff (reset)
    (state == sram_write_beats) && w_valid && w.last |-> (beat_cnt == len_q))
    else $error("wlast on a beat other than the final one");

endmodule

/* verilog/b_channel_delayer.sv */
module b_channel_delayer import axi_delay_pkg::*; #(
  parameter int unsigned delay_scale = 88
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    cpu_aw_valid,
  input  axi_ax_t cpu_aw,
  output logic    cpu_aw_ready,
  output logic    dev_aw_valid,
  input  logic    dev_aw_ready,
  input  logic    dev_b_valid,
  input  axi_b_t  dev_b,
  output logic    dev_b_ready,
  output logic    cpu_b_valid,
  output axi_b_t  cpu_b,
  input  logic    cpu_b_ready
);

  wait_state_e state;
  delay_acc_t  acc;
  axi_id_t     id_q;
  axi_b_t      slot_b;
  delay_t      slot_hold;
  logic        slot_full;
  logic        aw_fire;
  logic        dev_b_fire;
  logic        load;

  assign dev_aw_valid = cpu_aw_valid && (state == wait_idle);
  assign cpu_aw_ready = dev_aw_ready && (state == wait_idle);
  assign aw_fire = cpu_aw_valid && cpu_aw_ready;

  assign dev_b_ready = !slot_full;
  assign dev_b_fire = dev_b_valid && dev_b_ready;

  assign load = slot_full && (slot_hold == '0) && (!cpu_b_valid || cpu_b_ready);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= wait_idle;
      acc <= '0;
      slot_full <= 1'b0;
      cpu_b_valid <= 1'b0;
    end else begin
      if (aw_fire) begin
        state <= wait_waiting;
        acc <= '0;
      end else if (state == wait_waiting) begin
        if (dev_b_fire) begin
          state <= wait_idle;
          acc <= '0;
        end else begin
          acc <= acc + delay_acc_t'(delay_scale);
        end
      end
      // slot cannot fill and drain in the same cycle
      if (dev_b_fire) begin
        slot_full <= 1'b1;
      end else if (load) begin
        slot_full <= 1'b0;
      end
      if (load) begin
        cpu_b_valid <= 1'b1;
      end else if (cpu_b_ready) begin
        cpu_b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dev_b_fire) begin
      slot_b <= dev_b;
      slot_hold <= delay_t'(acc >> delay_frac_bits);
    end else if (slot_hold != '0) begin
      slot_hold <= slot_hold - 1'b1;
    end
    if (load) begin
      cpu_b <= slot_b;
    end
    if (aw_fire) begin
      id_q <= cpu_aw.id;
    end
  end

  a_b_stable: assert property (@(posedge clock) disable iff (reset)
    cpu_b_valid && !cpu_b_ready |=> cpu_b_valid && $stable(cpu_b))
    else $error("cpu_b changed before it was accepted");

  a_b_id: assert property (@(posedge clock) disable iff (reset)
    dev_b_fire |-> (dev_b.id == id_q))
    else $error("device B id differs from AW id");

endmodule

/* verilog/r_channel_delayer.sv */
module r_channel_delayer import axi_delay_pkg::*; #(
  parameter int unsigned delay_scale = 88,
  parameter int unsigned burst_max = 16
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    cpu_ar_valid,
  input  axi_ax_t cpu_ar,
  output logic    cpu_ar_ready,
  output logic    dev_ar_valid,
  input  logic    dev_ar_ready,
  input  logic    dev_r_valid,
  input  axi_r_t  dev_r,
  output logic    dev_r_ready,
  output logic    cpu_r_valid,
  output axi_r_t  cpu_r,
  input  logic    cpu_r_ready
);

  localparam int unsigned ptr_w = $clog2(burst_max);

  wait_state_e state;
  delay_acc_t  acc;
  axi_len_t    len_q;
  axi_len_t    beat_cnt;

  axi_r_t beat_mem [burst_max];
  delay_t hold [burst_max];

  // one extra bit tells full from empty
  logic [ptr_w:0]   wptr;
  logic [ptr_w:0]   rptr;
  logic [ptr_w:0]   fill;
  logic [ptr_w-1:0] wr_idx;
  logic [ptr_w-1:0] rd_idx;
  logic full;
  logic empty;
  logic ar_fire;
  logic dev_r_fire;
  logic load;

  assign wr_idx = wptr[ptr_w-1:0];
  assign rd_idx = rptr[ptr_w-1:0];
  assign fill = wptr - rptr;
  assign full = fill[ptr_w];
  assign empty = (fill == '0);

  // AR only goes through between bursts
  assign dev_ar_valid = cpu_ar_valid && (state == wait_idle);
  assign cpu_ar_ready = dev_ar_ready && (state == wait_idle);
  assign ar_fire = cpu_ar_valid && cpu_ar_ready;

  assign dev_r_ready = !full;
  assign dev_r_fire = dev_r_valid && dev_r_ready;

  // head leaves once its hold ran out and the output slot frees up
  assign load = !empty && (hold[rd_idx] == '0) && (!cpu_r_valid || cpu_r_ready);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= wait_idle;
      acc <= '0;
      beat_cnt <= '0;
    end else if (ar_fire) begin
      state <= wait_waiting;
      acc <= '0;
      beat_cnt <= '0;
    end else if (state == wait_waiting) begin
      if (dev_r_fire) begin
        acc <= '0;
        beat_cnt <= beat_cnt + 1'b1;
        if (dev_r.last) begin
          state <= wait_idle;
        end
      end else begin
        acc <= acc + delay_acc_t'(delay_scale);
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wptr <= '0;
      rptr <= '0;
      cpu_r_valid <= 1'b0;
    end else begin
      if (dev_r_fire) begin
        wptr <= wptr + 1'b1;
      end
      if (load) begin
        rptr <= rptr + 1'b1;
        cpu_r_valid <= 1'b1;
      end else if (cpu_r_ready) begin
        cpu_r_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < burst_max; i++) begin
      if (hold[i] != '0) begin
        hold[i] <= hold[i] - 1'b1;
      end
    end
    // capture overrides the countdown for the new slot
    if (dev_r_fire) begin
      beat_mem[wr_idx] <= dev_r;
      hold[wr_idx] <= delay_t'(acc >> delay_frac_bits);
    end
    if (load) begin
      cpu_r <= beat_mem[rd_idx];
    end
    if (ar_fire) begin
      len_q <= cpu_ar.len;
    end
  end

  a_r_stable: assert property (@(posedge clock) disable iff (reset)
    cpu_r_valid && !cpu_r_ready |=> cpu_r_valid && $stable(cpu_r))
    else $error("cpu_r changed before it was accepted");

  // a beat offered into a full buffer waits at the device
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    full && dev_r_valid |=> dev_r_valid && $stable(dev_r))
    else $error("device beat dropped while the buffer was full");

  // device framing must match the AR length
  a_burst_len: assert property (@(posedge clock) disable iff (reset)
    dev_r_fire |-> (dev_r.last == (beat_cnt == len_q)))
    else $error("device last does not match AR len");

endmodule
